/* src/ldm_pkg.sv */
`default_nettype none

package ldm_pkg;

        // ====================================================================
        // Register indices and instruction fields.
        // ====================================================================

        // Architectural program counter.
        localparam logic [3:0] REG_PC = 4'd15;

        // Extended scratch registers, extension bit plus 4-bit field.
        localparam logic [4:0] SCRATCH_BASE = 5'b1_0000;
        localparam logic [4:0] SCRATCH_PC   = 5'b1_0001;

        // Pointer step for each single-word transfer.
        localparam logic [11:0] XFER_OFFSET = 12'd4;

        // Data-processing MOV opcode.
        localparam logic [3:0] OPC_MOV = 4'b1101;

        // MOV R0,R0 with condition always.
        localparam logic [31:0] NOP_WORD = 32'hE1A0_0000;

        // Instruction class codes, bits 27:25 or 27:26.
        localparam logic [2:0] CLS_BLOCK = 3'b100;
        localparam logic [1:0] CLS_LS    = 2'b01;
        localparam logic [1:0] CLS_DP    = 2'b00;

        // ====================================================================
        // Instruction word, three decodes of the same 32 bits.
        // ====================================================================

        typedef struct packed {
                logic [3:0]  cond;
                logic [2:0]  cls;
                logic        p;
                logic        u;
                logic        s;
                logic        w;
                logic        l;
                logic [3:0]  rn;
                logic [15:0] reg_list;
        } block_fmt_t;

        typedef struct packed {
                logic [3:0]  cond;
                logic [1:0]  cls;
                logic        i;
                logic        p;
                logic        u;
                logic        b;
                logic        w;
                logic        l;
                logic [3:0]  rn;        // Pointer.
                logic [3:0]  rd;        // Source or destination.
                logic [11:0] offset;
        } ls_fmt_t;

        typedef struct packed {
                logic [3:0]  cond;
                logic [1:0]  cls;
                logic        i;
                logic [3:0]  opcode;
                logic        s;
                logic [3:0]  rn;
                logic [3:0]  rd;
                logic [7:0]  shift;
                logic [3:0]  rm;
        } dp_fmt_t;

        typedef union packed {
                block_fmt_t block_fmt;
                ls_fmt_t    ls_fmt;
                dp_fmt_t    dp_fmt;
        } arm_word_u;

        // Micro-op with extension bits for the widened register file.
        typedef struct packed {
                logic      ptr_hi;      // Pointer or destination extension.
                logic      src_hi;      // Data or second-operand extension.
                arm_word_u word;
        } uop_t;

        // Clear and stall controls, highest priority first.
        typedef struct packed {
                logic clear_wb;
                logic data_stall;
                logic clear_alu;
                logic stall_issue;
        } pipe_ctrl_t;

        typedef enum logic [2:0] {
                KIND_PASS,
                KIND_NONE,
                KIND_BASE_COPY,
                KIND_XFER,
                KIND_XFER_PC,
                KIND_BASE_RESTORE,
                KIND_PC_CODA
        } uop_kind_e;

        typedef enum logic [1:0] {
                ST_IDLE,
                ST_TRANSFER,
                ST_BASE_RESTORE,
                ST_PC_CODA
        } seq_state_e;

endpackage

`default_nettype wire

/* src/reg_list_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_list_scan
        import ldm_pkg::*;
(
        input  wire logic [15:0] i_list,
        output logic [3:0]       o_low_idx,
        output logic [15:0]      o_next_list,
        output logic             o_is_last,
        output logic             o_pc_last
);

        // ====================================================================
        // Lowest pending register.
        // ====================================================================

        // Scan from the top so the lowest set bit wins.
        always_comb
        begin
                o_low_idx = '0;
                for (int i = 15; i >= 0; i--)
                begin
                        if (i_list[i])
                        begin
                                o_low_idx = 4'(i);
                        end
                end
        end

        // ====================================================================
        // Remaining list and end flags.
        // ====================================================================

        // Drop the register being issued now.
        assign o_next_list = i_list & ~(16'h0001 << o_low_idx);

        // Nothing left after this one.
        assign o_is_last = (o_next_list == 16'h0000);

        // Only the PC is still pending.
        assign o_pc_last = (i_list == (16'h0001 << REG_PC));

endmodule

`default_nettype wire

/* src/block_xfer_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module block_xfer_seq
        import ldm_pkg::*;
(
        input  wire logic        i_clk,
        input  wire logic        i_reset,
        input  wire pipe_ctrl_t  i_ctrl,
        input  wire arm_word_u   i_instr,
        input  wire logic        i_instr_valid,
        output logic [15:0]      o_list,
        input  wire logic [3:0]  i_low_idx,
        input  wire logic [15:0] i_next_list,
        input  wire logic        i_is_last,
        input  wire logic        i_pc_last,
        output uop_kind_e        o_kind,
        output logic [3:0]       o_reg_idx,
        output logic             o_stall_decode
);

        seq_state_e  state_q;
        seq_state_e  state_d;
        logic [15:0] list_q;
        logic [15:0] list_d;
        logic        is_block;

        // Valid LDM or STM from fetch.
        assign is_block = i_instr_valid && (i_instr.block_fmt.cls == CLS_BLOCK);

        // Scanner works on the pending list.
        assign o_list    = list_q;
        assign o_reg_idx = i_low_idx;

        // Fetch holds while the sequence continues.
        assign o_stall_decode = (state_d != ST_IDLE);

        // ====================================================================
        // Kind selection and next state.
        // ====================================================================

        always_comb
        begin
                o_kind  = KIND_PASS;
                state_d = ST_IDLE;
                list_d  = list_q;

                // Anything other than a block transfer passes straight through.
                if (is_block)
                begin
                        case (state_q)
                        ST_IDLE:
                        begin
                                if (i_instr.block_fmt.reg_list == 16'h0000)
                                begin
                                        o_kind = KIND_NONE;
                                end
                                else
                                begin
                                        // Save base, then start the transfers.
                                        o_kind  = KIND_BASE_COPY;
                                        state_d = ST_TRANSFER;
                                        list_d  = i_instr.block_fmt.reg_list;
                                end
                        end

                        ST_TRANSFER:
                        begin
                                list_d = i_next_list;
                                if (i_pc_last && i_instr.block_fmt.l)
                                begin
                                        // PC load lands in scratch first.
                                        o_kind  = KIND_XFER_PC;
                                        state_d = i_instr.block_fmt.w ? ST_BASE_RESTORE
                                                                      : ST_PC_CODA;
                                end
                                else
                                begin
                                        o_kind = KIND_XFER;
                                        if (!i_is_last)
                                        begin
                                                state_d = ST_TRANSFER;
                                        end
                                        else if (i_instr.block_fmt.w)
                                        begin
                                                state_d = ST_BASE_RESTORE;
                                        end
                                end
                        end

                        ST_BASE_RESTORE:
                        begin
                                o_kind = KIND_BASE_RESTORE;
                                // PC coda only for a load that listed the PC.
                                if (i_instr.block_fmt.l && i_instr.block_fmt.reg_list[REG_PC])
                                begin
                                        state_d = ST_PC_CODA;
                                end
                        end

                        default:
                        begin
                                o_kind = KIND_PC_CODA;
                        end
                        endcase
                end
        end

        // ====================================================================
        // State register, clears and stalls in priority order.
        // ====================================================================

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_ctrl.clear_wb)
                begin
                        state_q <= ST_IDLE;
                        list_q  <= '0;
                end
                else if (i_ctrl.data_stall)
                begin
                        // Hold everything.
                end
                else if (i_ctrl.clear_alu)
                begin
                        state_q <= ST_IDLE;
                        list_q  <= '0;
                end
                else if (!i_ctrl.stall_issue)
                begin
                        state_q <= state_d;
                        list_q  <= list_d;
                end
        end

endmodule

`default_nettype wire

/* src/uop_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module uop_encoder
        import ldm_pkg::*;
(
        input  wire arm_word_u  i_instr,
        input  wire logic       i_instr_valid,
        input  wire uop_kind_e  i_kind,
        input  wire logic [3:0] i_reg_idx,
        input  wire logic       i_irq,
        input  wire logic       i_fiq,
        output uop_t            o_uop,
        output logic            o_uop_valid,
        output logic            o_user_bank,
        output logic            o_irq,
        output logic            o_fiq
);

        block_fmt_t blk;
        logic       in_block;
        logic       is_xfer;

        assign blk = i_instr.block_fmt;

        // Any kind other than pass means a valid block instruction.
        assign in_block = (i_kind != KIND_PASS);
        assign is_xfer  = (i_kind == KIND_XFER) || (i_kind == KIND_XFER_PC);

        // ====================================================================
        // Flags and interrupt masking.
        // ====================================================================

        // Pass follows fetch; empty list is dropped.
        assign o_uop_valid = (i_kind == KIND_PASS) ? i_instr_valid
                                                   : (i_kind != KIND_NONE);

        // S-bit transfers use the user bank unless a load restores the PC.
        assign o_user_bank = is_xfer && blk.s && (!blk.l || !blk.reg_list[REG_PC]);

        // No interrupt may split a block transfer.
        assign o_irq = i_irq && !in_block;
        assign o_fiq = i_fiq && !in_block;

        // ====================================================================
        // Micro-op word.
        // ====================================================================

        always_comb
        begin
                o_uop = '0;
                case (i_kind)
                KIND_PASS:
                begin
                        o_uop.word = i_instr;
                end

                KIND_NONE:
                begin
                        o_uop.word = NOP_WORD;
                end

                KIND_BASE_COPY:
                begin
                        // MOV R16, Rbase.
                        o_uop.word.dp_fmt.cond   = blk.cond;
                        o_uop.word.dp_fmt.cls    = CLS_DP;
                        o_uop.word.dp_fmt.opcode = OPC_MOV;
                        {o_uop.ptr_hi, o_uop.word.dp_fmt.rd} = SCRATCH_BASE;
                        o_uop.word.dp_fmt.rm     = blk.rn;
                end

                KIND_XFER, KIND_XFER_PC:
                begin
                        // LDR/STR Rx, [R16], #4 or pre-indexed with writeback.
                        o_uop.word.ls_fmt.cond   = blk.cond;
                        o_uop.word.ls_fmt.cls    = CLS_LS;
                        o_uop.word.ls_fmt.p      = blk.p;
                        o_uop.word.ls_fmt.u      = blk.u;
                        o_uop.word.ls_fmt.w      = blk.p;
                        o_uop.word.ls_fmt.l      = blk.l;
                        {o_uop.ptr_hi, o_uop.word.ls_fmt.rn} = SCRATCH_BASE;
                        o_uop.word.ls_fmt.offset = XFER_OFFSET;
                        if (i_kind == KIND_XFER_PC)
                        begin
                                // Loaded PC parks in R17.
                                {o_uop.src_hi, o_uop.word.ls_fmt.rd} = SCRATCH_PC;
                        end
                        else
                        begin
                                o_uop.word.ls_fmt.rd = i_reg_idx;
                        end
                end

                KIND_BASE_RESTORE:
                begin
                        // MOV Rbase, R16.
                        o_uop.word.dp_fmt.cond   = blk.cond;
                        o_uop.word.dp_fmt.cls    = CLS_DP;
                        o_uop.word.dp_fmt.opcode = OPC_MOV;
                        o_uop.word.dp_fmt.rd     = blk.rn;
                        {o_uop.src_hi, o_uop.word.dp_fmt.rm} = SCRATCH_BASE;
                end

                KIND_PC_CODA:
                begin
                        // MOV{S} PC, R17, S restores CPSR.
                        o_uop.word.dp_fmt.cond   = blk.cond;
                        o_uop.word.dp_fmt.cls    = CLS_DP;
                        o_uop.word.dp_fmt.opcode = OPC_MOV;
                        o_uop.word.dp_fmt.s      = blk.s;
                        o_uop.word.dp_fmt.rd     = REG_PC;
                        {o_uop.src_hi, o_uop.word.dp_fmt.rm} = SCRATCH_PC;
                end

                default:
                begin
                        o_uop = '0;
                end
                endcase
        end

endmodule

`default_nettype wire

/* src/ldm_stm_expander.sv */
`timescale 1ns/1ps
`default_nettype none

module ldm_stm_expander
        import ldm_pkg::*;
(
        input  wire logic       i_clk,
        input  wire logic       i_reset,
        input  wire pipe_ctrl_t i_ctrl,
        input  wire logic       i_irq,
        input  wire logic       i_fiq,
        input  wire arm_word_u  i_instr,
        input  wire logic       i_instr_valid,
        output uop_t            o_uop,
        output logic            o_uop_valid,
        output logic            o_user_bank,
        output logic            o_stall_decode,
        output logic            o_irq,
        output logic            o_fiq
);

        // ====================================================================
        // Sequencer to scanner and encoder.
        // ====================================================================

        logic [15:0] list;
        logic [3:0]  low_idx;
        logic [15:0] next_list;
        logic        is_last;
        logic        pc_last;
        uop_kind_e   kind;
        logic [3:0]  reg_idx;

        // Lowest pending register.
        reg_list_scan u_reg_list_scan (
                .i_list      (list),
                .o_low_idx   (low_idx),
                .o_next_list (next_list),
                .o_is_last   (is_last),
                .o_pc_last   (pc_last)
        );

        // State, pending list and kind.
        block_xfer_seq u_block_xfer_seq (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_ctrl         (i_ctrl),
                .i_instr        (i_instr),
                .i_instr_valid  (i_instr_valid),
                .o_list         (list),
                .i_low_idx      (low_idx),
                .i_next_list    (next_list),
                .i_is_last      (is_last),
                .i_pc_last      (pc_last),
                .o_kind         (kind),
                .o_reg_idx      (reg_idx),
                .o_stall_decode (o_stall_decode)
        );

        // Micro-op build and interrupt masking.
        uop_encoder u_uop_encoder (
                .i_instr       (i_instr),
                .i_instr_valid (i_instr_valid),
                .i_kind        (kind),
                .i_reg_idx     (reg_idx),
                .i_irq         (i_irq),
                .i_fiq         (i_fiq),
                .o_uop         (o_uop),
                .o_uop_valid   (o_uop_valid),
                .o_user_bank   (o_user_bank),
                .o_irq         (o_irq),
                .o_fiq         (o_fiq)
        );

endmodule

`default_nettype wire

/* bench/tb_ldm_stm_expander.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ldm_stm_expander
        import ldm_pkg::*;
();

        // One stim line, inputs then expected outputs.
        typedef struct packed {
                pipe_ctrl_t ctrl;
                logic       irq;
                logic       fiq;
                logic       valid;
                arm_word_u  instr;
                logic       exp_valid;
                uop_t       exp_uop;
                logic       exp_user;
                logic       exp_stall;
                logic       exp_irq;
                logic       exp_fiq;
        } stim_vec_t;

        logic       i_clk;
        logic       i_reset;
        pipe_ctrl_t i_ctrl;
        logic       i_irq;
        logic       i_fiq;
        arm_word_u  i_instr;
        logic       i_instr_valid;
        uop_t       o_uop;
        logic       o_uop_valid;
        logic       o_user_bank;
        logic       o_stall_decode;
        logic       o_irq;
        logic       o_fiq;

        stim_vec_t  vectors[$];
        int         check_errors;
        int         run_errors;
        int         cycle_limit;
        logic       stim_loaded;

        ldm_stm_expander u_ldm_stm_expander (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_ctrl         (i_ctrl),
                .i_irq          (i_irq),
                .i_fiq          (i_fiq),
                .i_instr        (i_instr),
                .i_instr_valid  (i_instr_valid),
                .o_uop          (o_uop),
                .o_uop_valid    (o_uop_valid),
                .o_user_bank    (o_user_bank),
                .o_stall_decode (o_stall_decode),
                .o_irq          (o_irq),
                .o_fiq          (o_fiq)
        );

        // 8 ns clock.
        initial
        begin
                i_clk = 1'b0;
                forever #4 i_clk = ~i_clk;
        end

        // ====================================================================
        // Stim file reader.
        // ====================================================================

        task automatic read_stim_file();
                int          fd;
                int          fields;
                int          line_no;
                string       line;
                logic [3:0]  f_ctrl;
                logic        f_irq;
                logic        f_fiq;
                logic        f_valid;
                logic [31:0] f_instr;
                logic        f_exp_valid;
                logic [33:0] f_exp_uop;
                logic        f_exp_user;
                logic        f_exp_stall;
                logic        f_exp_irq;
                logic        f_exp_fiq;
                stim_vec_t   v;

                line_no = 0;
                fd = $fopen("bench/stim_vectors.txt", "r");
                if (fd == 0)
                begin
                        $display("Could not open the stim file bench/stim_vectors.txt");
                        run_errors++;
                end
                else
                begin
                        while ($fgets(line, fd) != 0)
                        begin
                                line_no++;
                                // Comment and blank lines carry no vector.
                                if (line.len() > 1 && line.getc(0) != "#")
                                begin
                                        fields = $sscanf(line,
                                                "%b %b %b %b %h %b %h %b %b %b %b",
                                                f_ctrl, f_irq, f_fiq, f_valid, f_instr,
                                                f_exp_valid, f_exp_uop, f_exp_user,
                                                f_exp_stall, f_exp_irq, f_exp_fiq);
                                        if (fields != 11)
                                        begin
                                                $display("Stim line %0d has %0d fields, not 11",
                                                         line_no, fields);
                                                run_errors++;
                                        end
                                        else
                                        begin
                                                v.ctrl      = f_ctrl;
                                                v.irq       = f_irq;
                                                v.fiq       = f_fiq;
                                                v.valid     = f_valid;
                                                v.instr     = f_instr;
                                                v.exp_valid = f_exp_valid;
                                                v.exp_uop   = f_exp_uop;
                                                v.exp_user  = f_exp_user;
                                                v.exp_stall = f_exp_stall;
                                                v.exp_irq   = f_exp_irq;
                                                v.exp_fiq   = f_exp_fiq;
                                                vectors.push_back(v);
                                        end
                                end
                        end
                        $fclose(fd);
                end
        endtask

        // ====================================================================
        // Drive and compare.
        // ====================================================================

        // Called right at the rising edge.
        task automatic apply_vector(input stim_vec_t v);
                i_ctrl        <= v.ctrl;
                i_irq         <= v.irq;
                i_fiq         <= v.fiq;
                i_instr       <= v.instr;
                i_instr_valid <= v.valid;
        endtask

        task automatic check_uop(input int idx, input uop_t actual, input uop_t expected);
                if (actual !== expected)
                begin
                        $display("CHECK FAILED vector %0d: o_uop = %h, expected %h",
                                 idx, actual, expected);
                        check_errors++;
                end
        endtask

        task automatic check_flag(input int idx, input string name, input logic actual,
                                  input logic expected);
                if (actual !== expected)
                begin
                        $display("CHECK FAILED vector %0d: %s = %h, expected %h",
                                 idx, name, actual, expected);
                        check_errors++;
                end
        endtask

        task automatic compare_outputs(input int idx, input stim_vec_t v);
                check_flag(idx, "o_uop_valid", o_uop_valid, v.exp_valid);
                check_uop(idx, o_uop, v.exp_uop);
                check_flag(idx, "o_user_bank", o_user_bank, v.exp_user);
                check_flag(idx, "o_stall_decode", o_stall_decode, v.exp_stall);
                check_flag(idx, "o_irq", o_irq, v.exp_irq);
                check_flag(idx, "o_fiq", o_fiq, v.exp_fiq);
        endtask

        // ====================================================================
        // Main sequence.
        // ====================================================================

        initial
        begin
                check_errors  = 0;
                run_errors    = 0;
                cycle_limit   = 0;
                stim_loaded   = 1'b0;
                i_reset       = 1'b1;
                i_ctrl        = '0;
                i_irq         = 1'b0;
                i_fiq         = 1'b0;
                i_instr       = NOP_WORD;
                i_instr_valid = 1'b0;

                read_stim_file();
                if (vectors.size() == 0)
                begin
                        $display("The stim file gave no vectors to run");
                        run_errors++;
                end

                // Reset, one cycle per vector, and some slack.
                cycle_limit = vectors.size() + 10 + 20;
                stim_loaded = 1'b1;

                // Reset for 10 rising edges.
                repeat (10) @(posedge i_clk);
                i_reset <= 1'b0;

                // One vector per cycle, sampled mid-cycle.
                for (int k = 0; k < vectors.size(); k++)
                begin
                        @(posedge i_clk);
                        apply_vector(vectors[k]);
                        @(negedge i_clk);
                        compare_outputs(k, vectors[k]);
                end

                $display("Errors: %0d check, %0d other, over %0d vectors",
                         check_errors, run_errors, vectors.size());
                if (check_errors == 0 && run_errors == 0)
                begin
                        $display("Simulation passed");
                end
                else
                begin
                        $display("Simulation failed");
                end
                $finish;
        end

        // Run limit.
        initial
        begin
                wait (stim_loaded);
                repeat (cycle_limit) @(posedge i_clk);
                run_errors++;
                $display("Timeout, the run was still busy after %0d cycles", cycle_limit);
                $display("Errors: %0d check, %0d other, over %0d vectors",
                         check_errors, run_errors, vectors.size());
                $display("Simulation failed");
                $finish;
        end

endmodule

`default_nettype wire

/* bench/stim_vectors.txt */
# Inputs: ctrl (clear_wb data_stall clear_alu stall_issue) irq fiq valid instr
# Expected: valid uop(34 bits hex) user_bank stall irq fiq
# Pass-through, data op, single load, then a block word with valid low.
0000 1 1 1 E0821003 1 0E0821003 0 0 1 1
0000 1 0 1 E5912004 1 0E5912004 0 0 1 0
0000 1 1 0 E8A30012 0 0E8A30012 0 0 1 1
# STMIA R3!, {R1,R4}.
0000 1 1 1 E8A30012 1 2E1A00003 0 1 0 0
0000 1 1 1 E8A30012 1 2E4801004 0 1 0 0
0000 1 1 1 E8A30012 1 2E4804004 0 1 0 0
0000 1 1 1 E8A30012 1 1E1A03000 0 0 0 0
# LDMIA R5, {R2,PC}^.
0000 1 0 1 E8D58004 1 2E1A00005 0 1 0 0
0000 1 0 1 E8D58004 1 2E4902004 0 1 0 0
0000 1 0 1 E8D58004 1 3E4901004 0 1 0 0
0000 1 0 1 E8D58004 1 1E1B0F001 0 0 0 0
# Empty register list.
0000 1 1 1 E8820000 0 0E1A00000 0 0 0 0
# data_stall hold, clear_alu restart, then data_stall over clear_alu and stall_issue.
0000 0 1 1 E8A30012 1 2E1A00003 0 1 0 0
0100 0 1 1 E8A30012 1 2E4801004 0 1 0 0
0000 0 1 1 E8A30012 1 2E4801004 0 1 0 0
0010 0 1 1 E8A30012 1 2E4804004 0 1 0 0
0000 0 1 1 E8A30012 1 2E1A00003 0 1 0 0
0110 0 1 1 E8A30012 1 2E4801004 0 1 0 0
0001 0 1 1 E8A30012 1 2E4801004 0 1 0 0
0000 0 1 1 E8A30012 1 2E4801004 0 1 0 0
0000 0 1 1 E8A30012 1 2E4804004 0 1 0 0
0000 0 1 1 E8A30012 1 1E1A03000 0 0 0 0
# STMIB R6, {R0,R7}^ uses the user bank.
0000 1 1 1 E9C60081 1 2E1A00006 0 1 0 0
0000 1 1 1 E9C60081 1 2E5A00004 1 1 0 0
0000 1 1 1 E9C60081 1 2E5A07004 1 0 0 0
# clear_wb wins over data_stall and restarts.
1100 0 0 1 E8A30012 1 2E1A00003 0 1 0 0
0000 0 0 1 E8A30012 1 2E1A00003 0 1 0 0
0000 0 0 1 E8A30012 1 2E4801004 0 1 0 0
0000 0 0 1 E8A30012 1 2E4804004 0 1 0 0
0000 0 0 1 E8A30012 1 1E1A03000 0 0 0 0
# Back to plain flow.
0000 0 0 1 E1A00000 1 0E1A00000 0 0 0 0

/* ldm_stm_expander.f */
src/ldm_pkg.sv
src/reg_list_scan.sv
src/block_xfer_seq.sv
src/uop_encoder.sv
src/ldm_stm_expander.sv
bench/tb_ldm_stm_expander.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the expander testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps \
        --top-module tb_ldm_stm_expander \
        -f ldm_stm_expander.f \
        -Mdir obj_dir -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
        exit 0
else
        exit 1
fi
